// ==== Makefile ====
VERILATOR ?= verilator
TOP       := uart_top_tb
FILELIST  := build.f
VFLAGS    := --binary --assert --timing --timescale 1ns/100ps -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := test passed

SOURCES   := $(wildcard hw/*.sv) $(wildcard tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
hw/uart_cfg_pkg.sv
hw/uart_ctrl_pkg.sv
hw/baud_tick_gen.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_ctrl.sv
hw/uart_top.sv
tb/tb_clk_gen.sv
tb/uart_top_tb.sv

// ==== hw/baud_tick_gen.sv ====
module baud_tick_gen #(
  parameter int DIV = 104
) (
  input  logic clk,
  input  logic rstn,
  input  logic restart,
  output logic tick
);

  // Counter just wide enough for DIV - 1
  localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
  localparam logic [CNT_W-1:0] LAST = CNT_W'(DIV - 1);

  logic [CNT_W-1:0] cnt;

  // Free running divider, restart puts it back to the start of a period
  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt <= '0;
    end else if (restart) begin
      cnt <= '0;
    end else if (cnt == LAST) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // One cycle pulse on the last count, i.e. as the counter wraps
  // After a restart the first tick comes DIV cycles later
  assign tick = (cnt == LAST);

  // A divide by one would hold tick high all the time
  a_div_min: assert property (@(posedge clk) disable iff (!rstn) DIV >= 2);

endmodule

// ==== hw/uart_cfg_pkg.sv ====
package uart_cfg_pkg;

  // Frame format for the whole UART
  // 8N1 only, no parity and a single stop bit

  // Data bits per frame, sent LSB first
  localparam int DATA_BITS = 8;

  // Start bit plus data bits plus stop bit
  // Transmit bit counter loads this at the start of a frame
  localparam int FRAME_BITS = DATA_BITS + 2;

  // Receiver sample ticks per bit time
  // Receive tick generator runs this many times faster than the bit rate
  localparam int OVERSAMPLE = 16;

endpackage

// ==== hw/uart_ctrl.sv ====
module uart_ctrl (
  input  logic                               clk,
  input  logic                               rstn,
  input  logic                               ws,
  input  logic [uart_cfg_pkg::DATA_BITS-1:0] data,
  input  logic                               echo_en,
  input  logic [uart_cfg_pkg::DATA_BITS-1:0] rx_data,
  input  logic                               rx_valid,
  input  logic                               done,
  output logic                               load,
  output logic                               tx_restart,
  output logic [uart_cfg_pkg::DATA_BITS-1:0] tx_data,
  output logic                               busy,
  output logic                               overrun
);

  uart_ctrl_pkg::tx_state_t           state;
  uart_ctrl_pkg::tx_state_t           state_next;
  uart_ctrl_pkg::tx_src_t             src;
  logic                               ws_q;
  logic                               ws_rise;
  logic                               hold_full;
  logic [uart_cfg_pkg::DATA_BITS-1:0] hold_data;
  logic                               hold_take;
  logic                               capture;
  logic                               echo_in;

  // Previous ws, for the rising edge
  // A strobe already high when the FSM gets back to IDLE does not count
  always_ff @(posedge clk) begin
    if (!rstn) begin
      ws_q <= 1'b0;
    end else begin
      ws_q <= ws;
    end
  end

  assign ws_rise = ws && !ws_q;

  // Held echo byte wins over the host whenever the FSM is idle
  assign hold_take = (state == uart_ctrl_pkg::IDLE) && hold_full;
  assign src       = hold_take ? uart_ctrl_pkg::SRC_ECHO : uart_ctrl_pkg::SRC_HOST;

  // Byte is latched on the way into LOAD
  // Host data is taken on the cycle that sees ws low again
  assign capture = hold_take || (state == uart_ctrl_pkg::WAIT && !ws);

  // Next state
  always_comb begin
    state_next = state;
    case (state)
      uart_ctrl_pkg::IDLE: begin
        if (hold_full) begin
          state_next = uart_ctrl_pkg::LOAD;
        end else if (ws_rise) begin
          state_next = uart_ctrl_pkg::WAIT;
        end
      end
      uart_ctrl_pkg::WAIT: begin
        if (!ws) begin
          state_next = uart_ctrl_pkg::LOAD;
        end
      end
      uart_ctrl_pkg::LOAD: begin
        state_next = uart_ctrl_pkg::SEND;
      end
      uart_ctrl_pkg::SEND: begin
        // done is still low on the first SEND cycle, counter was just loaded
        if (done) begin
          state_next = uart_ctrl_pkg::IDLE;
        end
      end
      default: state_next = uart_ctrl_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= uart_ctrl_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Frame byte register, only meaningful from LOAD on
  always_ff @(posedge clk) begin
    if (capture) begin
      tx_data <= (src == uart_ctrl_pkg::SRC_ECHO) ? hold_data : data;
    end
  end

  // Load the shifter and line up the baud tick in the same cycle
  assign load       = (state == uart_ctrl_pkg::LOAD);
  assign tx_restart = (state == uart_ctrl_pkg::LOAD);

  // Host may write again once back in IDLE
  assign busy = (state == uart_ctrl_pkg::LOAD) || (state == uart_ctrl_pkg::SEND);

  assign echo_in = rx_valid && echo_en;

  // One entry echo hold
  // A byte arriving as the old one leaves still fits
  always_ff @(posedge clk) begin
    if (!rstn) begin
      hold_full <= 1'b0;
      overrun   <= 1'b0;
    end else begin
      overrun <= echo_in && hold_full && !hold_take;
      if (echo_in && (!hold_full || hold_take)) begin
        hold_full <= 1'b1;
      end else if (hold_take) begin
        hold_full <= 1'b0;
      end
    end
  end

  // Hold payload, the new byte is dropped on overrun
  always_ff @(posedge clk) begin
    if (echo_in && (!hold_full || hold_take)) begin
      hold_data <= rx_data;
    end
  end

  // Transmitter sees exactly one load per frame
  a_load_pulse: assert property (@(posedge clk) disable iff (!rstn) load |=> !load);

endmodule

// ==== hw/uart_ctrl_pkg.sv ====
package uart_ctrl_pkg;

  // Transmit control states
  // IDLE   waiting for a host strobe or a held echo byte
  // WAIT   ws seen high, waiting for its falling edge
  // LOAD   one cycle, loads the transmitter and restarts its baud tick
  // SEND   frame on the line until the bit counter runs out
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    WAIT = 2'd1,
    LOAD = 2'd2,
    SEND = 2'd3
  } tx_state_t;

  // Where the next transmit byte comes from
  typedef enum logic {
    SRC_HOST = 1'b0,
    SRC_ECHO = 1'b1
  } tx_src_t;

endpackage

// ==== hw/uart_rx.sv ====
module uart_rx (
  input  logic                               clk,
  input  logic                               rstn,
  input  logic                               rx,
  input  logic                               tick,
  output logic [uart_cfg_pkg::DATA_BITS-1:0] rx_data,
  output logic                               rx_valid,
  output logic                               frame_err
);

  localparam int SCNT_W = $clog2(uart_cfg_pkg::OVERSAMPLE);
  localparam int BIDX_W = $clog2(uart_cfg_pkg::DATA_BITS);

  // Half a bit from the start edge, then a whole bit per sample
  localparam logic [SCNT_W-1:0] HALF = SCNT_W'(uart_cfg_pkg::OVERSAMPLE / 2 - 1);
  localparam logic [SCNT_W-1:0] FULL = SCNT_W'(uart_cfg_pkg::OVERSAMPLE - 1);
  localparam logic [BIDX_W-1:0] LAST_BIT = BIDX_W'(uart_cfg_pkg::DATA_BITS - 1);

  // Receiver states, local to this module
  typedef enum logic [1:0] {
    RX_IDLE  = 2'd0,
    RX_START = 2'd1,
    RX_DATA  = 2'd2,
    RX_STOP  = 2'd3
  } rx_state_t;

  rx_state_t                        state;
  logic                             rx_meta;
  logic                             rx_sync;
  logic                             rx_prev;
  logic                             start_edge;
  logic [SCNT_W-1:0]                samp_cnt;
  logic [BIDX_W-1:0]                bit_idx;
  logic [uart_cfg_pkg::DATA_BITS-1:0] shreg;

  // Two flop synchronizer, plus one more flop for the edge detector
  // Reset high to match an idle line
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // High to low on the line may be a start bit
  assign start_edge = rx_prev && !rx_sync;

  // Receive FSM
  // Strobes default low and pulse for a single cycle
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state     <= RX_IDLE;
      samp_cnt  <= '0;
      bit_idx   <= '0;
      rx_valid  <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      rx_valid  <= 1'b0;
      frame_err <= 1'b0;
      case (state)
        RX_IDLE: begin
          // Edge seen on any clock, sample count starts from here
          if (start_edge) begin
            state    <= RX_START;
            samp_cnt <= '0;
          end
        end
        RX_START: begin
          if (tick) begin
            if (samp_cnt == HALF) begin
              samp_cnt <= '0;
              bit_idx  <= '0;
              // Still low at mid start bit, otherwise a glitch
              state    <= rx_sync ? RX_IDLE : RX_DATA;
            end else begin
              samp_cnt <= samp_cnt + 1'b1;
            end
          end
        end
        RX_DATA: begin
          if (tick) begin
            if (samp_cnt == FULL) begin
              samp_cnt <= '0;
              if (bit_idx == LAST_BIT) begin
                state <= RX_STOP;
              end else begin
                bit_idx <= bit_idx + 1'b1;
              end
            end else begin
              samp_cnt <= samp_cnt + 1'b1;
            end
          end
        end
        RX_STOP: begin
          if (tick) begin
            if (samp_cnt == FULL) begin
              // Mid stop bit, high means a good frame
              rx_valid  <= rx_sync;
              frame_err <= !rx_sync;
              samp_cnt  <= '0;
              state     <= RX_IDLE;
            end else begin
              samp_cnt <= samp_cnt + 1'b1;
            end
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Data shift register, LSB arrives first so shift in from the top
  always_ff @(posedge clk) begin
    if (state == RX_DATA && tick && samp_cnt == FULL) begin
      shreg <= {rx_sync, shreg[uart_cfg_pkg::DATA_BITS-1:1]};
    end
  end

  assign rx_data = shreg;

  // A frame ends either good or bad, never both
  a_rx_excl: assert property (@(posedge clk) disable iff (!rstn) !(rx_valid && frame_err));

endmodule

// ==== hw/uart_top.sv ====
module uart_top #(
  parameter int CLK_DIV = 104
) (
  input  logic                               clk,
  input  logic                               rstn,
  input  logic [uart_cfg_pkg::DATA_BITS-1:0] data,
  input  logic                               ws,
  input  logic                               rx,
  input  logic                               echo_en,
  output logic                               tx,
  output logic                               busy,
  output logic [uart_cfg_pkg::DATA_BITS-1:0] rx_data,
  output logic                               rx_valid,
  output logic                               frame_err,
  output logic                               overrun
);

  // Controller to transmitter
  logic                               load;
  logic                               tx_restart;
  logic [uart_cfg_pkg::DATA_BITS-1:0] tx_data;
  logic                               done;

  // Baud ticks
  logic                               tx_tick;
  logic                               rx_tick;

  // Bit rate tick, realigned at every frame load
  baud_tick_gen #(
    .DIV(CLK_DIV)
  ) tx_baud (
    .clk    (clk),
    .rstn   (rstn),
    .restart(tx_restart),
    .tick   (tx_tick)
  );

  // Oversample tick for the receiver, free running
  baud_tick_gen #(
    .DIV(CLK_DIV / uart_cfg_pkg::OVERSAMPLE)
  ) rx_baud (
    .clk    (clk),
    .rstn   (rstn),
    .restart(1'b0),
    .tick   (rx_tick)
  );

  uart_tx u_tx (
    .clk    (clk),
    .rstn   (rstn),
    .load   (load),
    .tick   (tx_tick),
    .tx_data(tx_data),
    .tx     (tx),
    .done   (done)
  );

  uart_rx u_rx (
    .clk      (clk),
    .rstn     (rstn),
    .rx       (rx),
    .tick     (rx_tick),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .frame_err(frame_err)
  );

  // Receive outputs also feed the echo path
  uart_ctrl u_ctrl (
    .clk       (clk),
    .rstn      (rstn),
    .ws        (ws),
    .data      (data),
    .echo_en   (echo_en),
    .rx_data   (rx_data),
    .rx_valid  (rx_valid),
    .done      (done),
    .load      (load),
    .tx_restart(tx_restart),
    .tx_data   (tx_data),
    .busy      (busy),
    .overrun   (overrun)
  );

endmodule

// ==== hw/uart_tx.sv ====
module uart_tx (
  input  logic                               clk,
  input  logic                               rstn,
  input  logic                               load,
  input  logic                               tick,
  input  logic [uart_cfg_pkg::DATA_BITS-1:0] tx_data,
  output logic                               tx,
  output logic                               done
);

  // Enough bits to hold FRAME_BITS itself
  localparam int CNT_W = $clog2(uart_cfg_pkg::FRAME_BITS + 1);
  localparam logic [CNT_W-1:0] FRAME_CNT = CNT_W'(uart_cfg_pkg::FRAME_BITS);

  // Data byte plus start bit in the LSB
  logic [uart_cfg_pkg::DATA_BITS:0] shifter;
  // Bits still to go in the current frame
  logic [CNT_W-1:0]                 bit_cnt;
  logic                             sending;

  assign sending = (bit_cnt != '0);

  // Shift register
  // All ones at reset so the line idles high
  always_ff @(posedge clk) begin
    if (!rstn) begin
      shifter <= '1;
    end else if (load) begin
      // Start bit goes out first, on the cycle after load
      shifter <= {tx_data, 1'b0};
    end else if (tick && sending) begin
      // Ones fill in from the top and become the stop bit
      shifter <= {1'b1, shifter[uart_cfg_pkg::DATA_BITS:1]};
    end
  end

  // Bit counter
  // One tick per bit, the last tick closes the stop bit
  always_ff @(posedge clk) begin
    if (!rstn) begin
      bit_cnt <= '0;
    end else if (load) begin
      bit_cnt <= FRAME_CNT;
    end else if (tick && sending) begin
      bit_cnt <= bit_cnt - 1'b1;
    end
  end

  // Line straight from the shifter flop, no glitches
  assign tx = shifter[0];

  // Frame complete once every bit has had its full tick period
  assign done = !sending;

  // Controller only loads a new frame once the previous one is out
  a_load_idle: assert property (@(posedge clk) disable iff (!rstn) load |-> bit_cnt == '0);

endmodule

// ==== tb/tb_clk_gen.sv ====
module tb_clk_gen #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rstn
);
  timeunit 1ns;
  timeprecision 100ps;

  // Free running clock, low at time zero
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset held over the first rising edges
  // Released on a falling edge so no rising edge sees it change
  initial begin
    rstn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
  end

endmodule

// ==== tb/uart_cases.txt ====
# Columns: operation letter, byte in hex, echo_en (0 or 1)
# T host transmit, R receive, F receive with low stop bit, O echo overrun
T 55 0
T a3 0
T 00 1
T ff 0
R 3c 0
R 81 0
R c7 1
R 00 1
F 96 0
F 7e 1
R 5a 1
T 10 1
O 69 1
O e2 1
R 0f 0
T c3 0

// ==== tb/uart_top_tb.sv ====
module uart_top_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_DIV   = 32;
  localparam int FRAME_CYC = uart_cfg_pkg::FRAME_BITS * CLK_DIV;

  logic       clk;
  logic       rstn;
  logic [7:0] data;
  logic       ws;
  logic       rx;
  logic       echo_en;
  logic       tx;
  logic       busy;
  logic [7:0] rx_data;
  logic       rx_valid;
  logic       frame_err;
  logic       overrun;

  // Strobe counts, sampled on falling edges
  int         valid_cnt;
  int         ferr_cnt;
  int         ovr_cnt;
  logic [7:0] last_rx;
  integer     seed;

  tb_clk_gen #(.PERIOD(10), .RESET_CYCLES(2)) clk_gen (.clk(clk), .rstn(rstn));

  uart_top #(.CLK_DIV(CLK_DIV)) DUT (
    .clk      (clk),
    .rstn     (rstn),
    .data     (data),
    .ws       (ws),
    .rx       (rx),
    .echo_en  (echo_en),
    .tx       (tx),
    .busy     (busy),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .frame_err(frame_err),
    .overrun  (overrun)
  );

  // Each one cycle strobe is seen by exactly one falling edge
  always @(negedge clk) begin
    if (rstn !== 1'b1) begin
      valid_cnt = 0;
      ferr_cnt  = 0;
      ovr_cnt   = 0;
      last_rx   = '0;
    end else begin
      if (rx_valid === 1'b1) begin
        valid_cnt++;
        last_rx = rx_data;
      end
      if (frame_err === 1'b1) ferr_cnt++;
      if (overrun === 1'b1) ovr_cnt++;
    end
  end

  task automatic fail_stop();
    $display("test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // Poll for the start bit on tx
  task automatic wait_start(input int limit);
    int n;
    n = 0;
    while (tx !== 1'b0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (tx !== 1'b0) begin
      $display("Timeout: no start bit appeared on tx within %0d cycles", limit);
      fail_stop();
    end
  endtask

  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    while (busy !== 1'b0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (busy !== 1'b0) begin
      $display("Timeout: busy did not drop after the frame ended");
      fail_stop();
    end
  endtask

  // Whole frame checked on every cycle from the start edge
  // Catches wrong bit values as well as wrong bit lengths
  task automatic expect_frame(input logic [7:0] b, input int limit);
    logic [9:0] bits;
    int         i;
    int         c;
    bits = {1'b1, b, 1'b0};
    wait_start(limit);
    for (i = 0; i < uart_cfg_pkg::FRAME_BITS; i++) begin
      for (c = 0; c < CLK_DIV; c++) begin
        assert (tx === bits[0]) else begin
          $display("Fail at %0d ns: frame %h bit %0d cycle %0d, tx %b, expected %b",
                   $time, b, i, c, tx, bits[0]);
          fail_stop();
        end
        assert (busy === 1'b1) else begin
          $display("Fail at %0d ns: busy low during frame %h", $time, b);
          fail_stop();
        end
        @(negedge clk);
      end
      bits = bits >> 1;
    end
    wait_idle(4);
    assert (tx === 1'b1) else begin
      $display("Fail at %0d ns: tx not idle after frame %h", $time, b);
      fail_stop();
    end
  endtask

  // Line must stay idle for the given number of cycles
  task automatic expect_line_idle(input int cycles);
    int k;
    for (k = 0; k < cycles; k++) begin
      assert (tx === 1'b1) else begin
        $display("Fail at %0d ns: unexpected frame on tx", $time);
        fail_stop();
      end
      @(negedge clk);
    end
  endtask

  // Serial frame into rx, LSB first, stop bit as given
  task automatic send_frame(input logic [7:0] b, input logic stop);
    logic [9:0] bits;
    int         i;
    bits = {stop, b, 1'b0};
    for (i = 0; i < uart_cfg_pkg::FRAME_BITS; i++) begin
      rx = bits[0];
      repeat (CLK_DIV) @(negedge clk);
      bits = bits >> 1;
    end
    rx = 1'b1;
  endtask

  // ws high for one cycle, data held through the low sample
  task automatic host_write(input logic [7:0] b);
    ws   = 1'b1;
    data = b;
    @(negedge clk);
    ws = 1'b0;
  endtask

  task automatic compare_count(input string what, input int got, input int exp);
    assert (got == exp) else begin
      $display("Fail at %0d ns: %s count %0d, expected %0d", $time, what, got, exp);
      fail_stop();
    end
  endtask

  task automatic receive_case(input logic [7:0] b, input logic echo);
    int v0;
    int f0;
    v0 = valid_cnt;
    f0 = ferr_cnt;
    // Echo frame starts during the received stop bit
    fork
      send_frame(b, 1'b1);
      if (echo) expect_frame(b, 12 * CLK_DIV);
      else expect_line_idle(13 * CLK_DIV);
    join
    compare_count("rx_valid", valid_cnt, v0 + 1);
    compare_count("frame_err", ferr_cnt, f0);
    assert (last_rx === b) else begin
      $display("Fail at %0d ns: rx_data %h, expected %h", $time, last_rx, b);
      fail_stop();
    end
  endtask

  task automatic framing_case(input logic [7:0] b);
    int v0;
    int f0;
    v0 = valid_cnt;
    f0 = ferr_cnt;
    // Low stop bit, nothing is echoed even with echo on
    fork
      send_frame(b, 1'b0);
      expect_line_idle(13 * CLK_DIV);
    join
    compare_count("frame_err", ferr_cnt, f0 + 1);
    compare_count("rx_valid", valid_cnt, v0);
  endtask

  task automatic overrun_case(input logic [7:0] b);
    logic [7:0] first;
    logic [7:0] second;
    int         v0;
    int         o0;
    // Two bytes that differ for every b, so a wrong echo shows
    first  = ~b;
    second = b ^ 8'h3c;
    v0     = valid_cnt;
    o0     = ovr_cnt;
    // Host write parked in WAIT, so the first echo byte stays in the hold register
    ws   = 1'b1;
    data = b;
    fork
      send_frame(first, 1'b1);
      expect_line_idle(FRAME_CYC);
    join
    compare_count("rx_valid", valid_cnt, v0 + 1);
    ws = 1'b0;
    // Second byte lands while the host frame is on the line
    fork
      expect_frame(b, 8);
      begin
        repeat (2) @(negedge clk);
        send_frame(second, 1'b1);
      end
      begin
        repeat (4 * CLK_DIV) @(negedge clk);
        assert (busy === 1'b1) else begin
          $display("Fail at %0d ns: busy low in the middle of a host frame", $time);
          fail_stop();
        end
        ws   = 1'b1;
        data = b ^ 8'h5a;
        @(negedge clk);
        ws = 1'b0;
      end
    join
    compare_count("overrun", ovr_cnt, o0 + 1);
    compare_count("rx_valid", valid_cnt, v0 + 2);
    // First byte comes back, second byte and the ignored write do not
    expect_frame(first, 16);
    expect_line_idle(13 * CLK_DIV);
    compare_count("overrun", ovr_cnt, o0 + 1);
  endtask

  initial begin
    int         fd;
    int         n;
    int         gap;
    int         echo;
    int         code;
    int         ncase;
    string      line;
    logic [7:0] op;
    logic [7:0] b;
    data    = '0;
    ws      = 1'b0;
    rx      = 1'b1;
    echo_en = 1'b0;
    seed    = 36;
    ncase   = 0;
    n       = 0;
    while (rstn !== 1'b1 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (rstn !== 1'b1) begin
      $display("Timeout: reset was never released");
      fail_stop();
    end
    @(negedge clk);
    assert (tx === 1'b1 && busy === 1'b0 && rx_valid === 1'b0 &&
            frame_err === 1'b0 && overrun === 1'b0) else begin
      $display("Fail at %0d ns: outputs not idle after reset, tx %b busy %b", $time, tx, busy);
      fail_stop();
    end
    fd = $fopen("tb/uart_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file tb/uart_cases.txt");
      fail_stop();
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 2 && line[0] != "#") begin
        code = $sscanf(line, "%c %h %d", op, b, echo);
        if (code != 3) begin
          $display("Malformed line in the case file: %s", line);
          fail_stop();
        end
        // Random idle time between cases
        echo_en = echo[0];
        gap     = 4 + ($random(seed) & 31);
        repeat (gap) @(negedge clk);
        ncase++;
        if (op == "T") begin
          host_write(b);
          expect_frame(b, 8);
        end else if (op == "R") begin
          receive_case(b, echo[0]);
        end else if (op == "F") begin
          framing_case(b);
        end else if (op == "O") begin
          overrun_case(b);
        end else begin
          $display("Unknown operation %c in the case file", op);
          fail_stop();
        end
      end
    end
    $fclose(fd);
    if (ncase == 0) begin
      $display("No cases were read from tb/uart_cases.txt");
      fail_stop();
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule
